/* sim.f */
logic/ddrseq_pkg.sv
logic/cmd_mem.sv
logic/cmd_issue.sv
logic/pause_timer.sv
logic/seq_fsm.sv
logic/ddr_sequencer.sv
tb/seq_checker.sv
tb/tb_ddr_sequencer.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ddr_sequencer
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing -j 0

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf $(OBJ_DIR)

/* tb/tb_ddr_sequencer.sv */
`timescale 1ns/1ns

module tb_ddr_sequencer;
    import ddrseq_pkg::*;

    localparam int n_tests   = 6;
    localparam int max_words = 16;

    logic        mclk;
    logic        rst;
    apb_req_t    apb_req;
    logic        pready;
    logic        run_seq;
    logic [9:0]  run_addr;
    logic        ddr_rst;
    logic        run_busy;
    logic        run_done;
    ddr_cmd_t    ddr_cmd;

    logic        arm;
    logic        abort_exp;
    int          exp_n;
    ddr_cmd_t    exp_cmd [0:15];
    int          exp_gap [0:15];
    int          errors;
    int          tests_run;
    logic        check_done;
    int          tb_errors;

    // stimulus table
    logic [31:0] tbl_words [n_tests][max_words];
    int          tbl_len   [n_tests];
    logic [9:0]  tbl_addr  [n_tests];
    int          tbl_abort [n_tests];      // edges after run_seq, 0 = none
    int          tbl_keep  [n_tests];      // commands seen before abort
    bit          tbl_noload[n_tests];      // memory already holds the words
    bit          tbl_late  [n_tests];      // write first word of next entry mid run

    ddr_sequencer DUT (
        .mclk(mclk), .rst(rst), .apb_req(apb_req), .pready(pready),
        .run_seq(run_seq), .run_addr(run_addr), .ddr_rst(ddr_rst),
        .run_busy(run_busy), .run_done(run_done), .ddr_cmd(ddr_cmd)
    );

    seq_checker chk (
        .mclk(mclk), .rst(rst), .ddr_cmd(ddr_cmd), .run_busy(run_busy),
        .run_done(run_done), .pready(pready), .ddr_rst(ddr_rst), .arm(arm),
        .abort_exp(abort_exp), .exp_n(exp_n), .exp_cmd(exp_cmd), .exp_gap(exp_gap),
        .errors(errors), .tests_run(tests_run), .check_done(check_done)
    );

    initial begin
        mclk = 1'b0;
        forever #4 mclk = ~mclk;
    end

    // non-NOP words get random bank and address
    function automatic logic [31:0] make_word(input bit done, input bit ap,
                                              input logic [2:0] op, input int len);
        if (op == 3'b111) return {done, ap, op, 17'b0, 10'(len)};
        return {done, ap, op, 3'($urandom), 9'b0, 15'($urandom)};
    endfunction

    task automatic put(input int t, input logic [31:0] w);
        tbl_words[t][tbl_len[t]] = w;
        tbl_len[t]++;
    endtask

    // expected stream from the padding rules
    task automatic build_expect(input int t);
        int          i;
        int          gap;
        logic [31:0] w;
        exp_n = 0;
        gap   = 2;                                    // prime plus fetch
        for (i = 0; i < tbl_len[t]; i++) begin
            w = tbl_words[t][i];
            if (w[29:27] != 3'b111) begin
                exp_cmd[exp_n] = ddr_cmd_t'({w[29:24], w[14:0]});
                exp_gap[exp_n] = gap;
                exp_n++;
                gap = 0;
            end else begin
                gap++;                                // the NOP itself
            end
            if (w[31]) break;                         // no padding after last word
            gap += int'(w[30]);
            if (w[29:27] == 3'b111) gap += int'(w[9:0]);
        end
        if (tbl_abort[t] > 0) exp_n = tbl_keep[t];
        abort_exp = (tbl_abort[t] > 0);
    endtask

    task automatic apb_write(input logic [9:0] addr, input logic [31:0] data, output int stalls);
        @(posedge mclk);
        #1;
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: {addr, 2'b00}, pwdata: data};
        @(posedge mclk);
        #1;
        apb_req.penable = 1'b1;                       // access phase
        stalls = 0;
        @(negedge mclk);
        while (!pready && stalls < 500) begin
            stalls++;
            @(negedge mclk);
        end
        if (!pready) begin
            $display("ERROR: APB write to word %0d never got pready", addr);
            tb_errors++;
        end
        @(posedge mclk);
        #1;
        apb_req = '0;
    endtask

    task automatic run_entry(input int t);
        int i;
        int n;
        int stalls;
        if (!tbl_noload[t]) begin
            for (i = 0; i < tbl_len[t]; i++) apb_write(tbl_addr[t] + 10'(i), tbl_words[t][i], stalls);
        end
        build_expect(t);
        @(posedge mclk);
        #1;
        run_seq  = 1'b1;
        run_addr = tbl_addr[t];
        arm      = 1'b1;
        @(posedge mclk);
        #1;
        run_seq = 1'b0;
        arm     = 1'b0;
        fork
            if (tbl_abort[t] > 0) begin
                repeat (tbl_abort[t]) @(posedge mclk);
                #1 ddr_rst = 1'b1;
            end
            if (tbl_late[t]) begin
                repeat (1) @(posedge mclk);
                apb_write(tbl_addr[t + 1], tbl_words[t + 1][0], stalls);
                if (stalls == 0 || run_busy) begin
                    $display("ERROR: APB write during run was not held until idle");
                    tb_errors++;
                end
            end
            begin
                n = 0;
                @(posedge mclk);
                while (!check_done && n < 1000) begin
                    @(posedge mclk);
                    n++;
                end
                if (!check_done) begin
                    $display("ERROR: checker did not finish test %0d", t);
                    tb_errors++;
                end
            end
        join
        #1 ddr_rst = 1'b0;
    endtask

    initial begin
        int t;
        rst = 1'b1;
        apb_req = '0;
        run_seq = 1'b0;
        run_addr = '0;
        ddr_rst = 1'b0;
        arm = 1'b0;
        abort_exp = 1'b0;
        exp_n = 0;
        tb_errors = 0;
        void'($urandom(32'hc714bcd1));
        for (t = 0; t < n_tests; t++) begin
            tbl_len[t] = 0;
            tbl_abort[t] = 0;
            tbl_keep[t] = 0;
            tbl_noload[t] = 0;
            tbl_late[t] = 0;
        end
        // back to back commands from a nonzero address
        tbl_addr[0] = 10'd37;
        put(0, make_word(0, 0, 3'b011, 0));
        put(0, make_word(0, 0, 3'b100, 0));
        put(0, make_word(0, 0, 3'b101, 0));
        put(0, make_word(1, 0, 3'b010, 0));
        // NOP stretches of 0, 3 and 7
        tbl_addr[1] = 10'd100;
        put(1, make_word(0, 0, 3'b011, 0));
        put(1, make_word(0, 0, 3'b111, 0));
        put(1, make_word(0, 0, 3'b100, 0));
        put(1, make_word(0, 0, 3'b111, 3));
        put(1, make_word(0, 0, 3'b101, 0));
        put(1, make_word(0, 0, 3'b111, 7));
        put(1, make_word(1, 0, 3'b010, 0));
        // add_pause, alone and on NOPs
        tbl_addr[2] = 10'd200;
        put(2, make_word(0, 1, 3'b011, 0));
        put(2, make_word(0, 1, 3'b100, 0));
        put(2, make_word(0, 1, 3'b111, 2));
        put(2, make_word(0, 0, 3'b101, 0));
        put(2, make_word(0, 1, 3'b111, 0));
        put(2, make_word(1, 0, 3'b000, 0));
        // abort inside a long pause
        tbl_addr[3] = 10'd300;
        put(3, make_word(0, 0, 3'b011, 0));
        put(3, make_word(0, 0, 3'b111, 20));
        put(3, make_word(1, 0, 3'b100, 0));
        tbl_abort[3] = 6;
        tbl_keep[3] = 1;
        // write held during run, then seen by the rerun
        tbl_addr[4] = 10'd400;
        put(4, make_word(0, 0, 3'b011, 0));
        put(4, make_word(0, 0, 3'b100, 0));
        put(4, make_word(1, 0, 3'b101, 0));
        tbl_late[4] = 1;
        tbl_addr[5] = 10'd400;
        tbl_noload[5] = 1;
        put(5, make_word(0, 0, 3'b010, 0));
        put(5, tbl_words[4][1]);
        put(5, tbl_words[4][2]);

        repeat (4) @(posedge mclk);
        #1 rst = 1'b0;
        repeat (2) @(posedge mclk);
        for (t = 0; t < n_tests; t++) run_entry(t);
        repeat (2) @(posedge mclk);
        $display("tests run %0d, errors %0d", tests_run, errors + tb_errors);
        if (errors + tb_errors == 0 && tests_run == n_tests) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* tb/seq_checker.sv */
`timescale 1ns/1ns

module seq_checker (
    input  logic                 mclk,
    input  logic                 rst,
    input  ddrseq_pkg::ddr_cmd_t ddr_cmd,
    input  logic                 run_busy,
    input  logic                 run_done,
    input  logic                 pready,
    input  logic                 ddr_rst,          // abort as driven to the DUT
    input  logic                 arm,              // high with run_seq
    input  logic                 abort_exp,        // this run gets ddr_rst
    input  int                   exp_n,            // commands expected
    input  ddrseq_pkg::ddr_cmd_t exp_cmd [0:15],
    input  int                   exp_gap [0:15],   // NOP cycles before each cmd
    output int                   errors,
    output int                   tests_run,
    output logic                 check_done
);
    import ddrseq_pkg::*;

    localparam int run_limit = 400;                // cycles per run
    localparam int arm_limit = 20000;              // idle time between runs

    task automatic value_fail(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("CHECK FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
        errors++;
    endtask

    task automatic check_run();
        int  idx;
        int  gap;
        int  cyc;
        int  err0;
        bit  fin;
        bit  rst_seen;
        idx      = 0;
        gap      = 0;
        cyc      = 0;
        fin      = 0;
        rst_seen = 0;
        err0     = errors;
        while (!fin) begin
            @(negedge mclk);
            cyc++;
            if (cyc > run_limit) begin
                $display("ERROR: run did not end within %0d cycles", run_limit);
                errors++;
                fin = 1;
            end else if (!run_busy) begin                   // run over
                if (abort_exp) begin
                    if (run_done !== 1'b0) value_fail("run_done", 0, run_done);
                    if (ddr_cmd !== nop_cmd) value_fail("ddr_cmd", nop_cmd, ddr_cmd);
                end else begin
                    if (run_done !== 1'b1) value_fail("run_done", 1, run_done);
                    if (gap != 0) begin
                        $display("ERROR: run_done not in the cycle after the last command");
                        errors++;
                    end
                end
                if (idx != exp_n) value_fail("cmd_count", exp_n, idx);
                @(negedge mclk);
                if (run_done !== 1'b0) value_fail("run_done", 0, run_done);   // one cycle wide
                fin = 1;
            end else if (rst_seen) begin
                value_fail("run_busy", 0, run_busy);        // abort takes one cycle
                fin = 1;
            end else if (run_done) begin
                $display("ERROR: run_done high while run_busy is high");
                errors++;
            end else if (ddr_cmd !== nop_cmd) begin
                if (idx >= exp_n) begin
                    $display("ERROR: unexpected command %h at t=%0t", ddr_cmd, $time);
                    errors++;
                end else begin
                    if (ddr_cmd !== exp_cmd[idx]) value_fail("ddr_cmd", exp_cmd[idx], ddr_cmd);
                    if (gap != exp_gap[idx]) value_fail("nop_gap", exp_gap[idx], gap);
                end
                idx++;
                gap = 0;
            end else begin
                gap++;                                      // NOP on the bus
            end
            rst_seen = (ddr_rst === 1'b1);
        end
        tests_run++;
        if (errors == err0) $display("test %0d: ok, %0d commands", tests_run - 1, idx);
        else $display("test %0d: %0d errors", tests_run - 1, errors - err0);
        check_done = 1'b1;
    endtask

    initial begin
        int n;
        errors     = 0;
        tests_run  = 0;
        check_done = 1'b0;
        n = 0;
        while (rst !== 1'b0 && n < 100) begin               // wait out reset
            @(negedge mclk);
            n++;
        end
        if (rst !== 1'b0) begin
            $display("ERROR: reset was never released");
            errors++;
        end
        @(negedge mclk);
        // idle values after reset
        if (ddr_cmd !== nop_cmd) value_fail("ddr_cmd", nop_cmd, ddr_cmd);
        if (run_busy !== 1'b0) value_fail("run_busy", 0, run_busy);
        if (run_done !== 1'b0) value_fail("run_done", 0, run_done);
        if (pready !== 1'b1) value_fail("pready", 1, pready);
        forever begin
            n = 0;
            while (!arm && n < arm_limit) begin
                @(negedge mclk);
                n++;
            end
            if (n >= arm_limit) begin
                $display("ERROR: no run started within %0d cycles", arm_limit);
                errors++;
            end
            check_done = 1'b0;
            check_run();
        end
    end

endmodule

/* logic/ddr_sequencer.sv */
`timescale 1ns/1ns

module ddr_sequencer (
    input  logic                                 mclk,
    input  logic                                 rst,
    // apb command memory load
    input  ddrseq_pkg::apb_req_t                 apb_req,
    output logic                                 pready,
    // run control
    input  logic                                 run_seq,
    input  logic [ddrseq_pkg::cmd_addr_bits-1:0] run_addr,
    input  logic                                 ddr_rst,
    output logic                                 run_busy,
    output logic                                 run_done,
    // ddr3 command bus
    output ddrseq_pkg::ddr_cmd_t                 ddr_cmd
);
    import ddrseq_pkg::*;

    logic                     rd_en;                   // fsm fetch strobe
    logic [cmd_addr_bits-1:0] rd_addr;
    logic [cmd_word_bits-1:0] rd_word;                 // memory read register
    logic                     busy;
    cmd_fields_t              fields;                  // decoded word
    logic                     issue_en;
    logic                     load;                    // start pause count
    logic                     expired;

    // command storage, apb write side
    cmd_mem u_cmd_mem (
        .mclk     (mclk),
        .rst      (rst),
        .apb_req  (apb_req),
        .pready   (pready),
        .busy     (busy),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_word  (rd_word)
    );

    // word decode and command bus register
    cmd_issue u_cmd_issue (
        .mclk     (mclk),
        .rst      (rst),
        .rd_word  (rd_word),
        .issue_en (issue_en),
        .fields   (fields),
        .ddr_cmd  (ddr_cmd)
    );

    // NOP stretch counter
    pause_timer u_pause_timer (
        .mclk      (mclk),
        .rst       (rst),
        .load      (load),
        .pause_len (fields.pause_len),
        .expired   (expired)
    );

    // sequencer control
    seq_fsm u_seq_fsm (
        .mclk     (mclk),
        .rst      (rst),
        .run_seq  (run_seq),
        .run_addr (run_addr),
        .ddr_rst  (ddr_rst),
        .fields   (fields),
        .expired  (expired),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .issue_en (issue_en),
        .load     (load),
        .busy     (busy),
        .run_busy (run_busy),
        .run_done (run_done)
    );

endmodule

/* logic/seq_fsm.sv */
`timescale 1ns/1ns

module seq_fsm (
    input  logic                                 mclk,
    input  logic                                 rst,
    input  logic                                 run_seq,    // start pulse, idle only
    input  logic [ddrseq_pkg::cmd_addr_bits-1:0] run_addr,   // first word of sequence
    input  logic                                 ddr_rst,    // sync abort, level
    input  ddrseq_pkg::cmd_fields_t              fields,     // current word decode
    input  logic                                 expired,    // pause timer at zero
    output logic                                 rd_en,
    output logic [ddrseq_pkg::cmd_addr_bits-1:0] rd_addr,
    output logic                                 issue_en,
    output logic                                 load,
    output logic                                 busy,       // to apb side
    output logic                                 run_busy,
    output logic                                 run_done
);
    import ddrseq_pkg::*;

    seq_state_e               state;
    seq_state_e               state_nxt;
    logic [cmd_addr_bits-1:0] addr_q;                  // next word to fetch
    logic                     extra_q;                 // add_pause pending after timed NOP
    ddr_op_e                  cur_op;
    logic                     long_nop;                // NOP with nonzero stretch
    logic                     need_pause;
    logic                     start;

    assign cur_op     = ddr_op_e'({fields.cmd.ras_n, fields.cmd.cas_n, fields.cmd.we_n});
    assign long_nop   = (cur_op == op_nop) && (fields.pause_len != '0);
    assign need_pause = long_nop || fields.add_pause;
    assign start      = (state == st_idle) && run_seq && !ddr_rst;

    // next state
    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (run_seq) begin
                    state_nxt = st_prime;
                end
            end
            st_prime: state_nxt = st_issue;            // first word lands in rd_word
            st_issue: begin
                if (fields.done) begin
                    state_nxt = st_done;               // padding on last word dropped
                end else if (need_pause) begin
                    state_nxt = st_pause;
                end
            end
            st_pause: begin
                if (expired && !extra_q) begin
                    state_nxt = st_issue;              // prefetched word waiting
                end
            end
            st_done: state_nxt = st_idle;
            default: state_nxt = st_idle;
        endcase
        if (ddr_rst) begin
            state_nxt = st_idle;                       // abort wins everywhere
        end
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // fetch address, moves only when a word is taken
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            addr_q <= '0;
        end else if (start) begin
            addr_q <= run_addr;
        end else if (rd_en) begin
            addr_q <= addr_q + 1'b1;                   // wraps at 1K
        end
    end

    // one more NOP after a timed stretch
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            extra_q <= 1'b0;
        end else if (state == st_issue) begin
            extra_q <= fields.add_pause && long_nop;   // plain add_pause uses the timer at 0
        end else if ((state == st_pause) && expired) begin
            extra_q <= 1'b0;                           // this cycle is the extra NOP
        end
    end

    // done pulse the cycle after the last word is on the bus
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            run_done <= 1'b0;
        end else begin
            run_done <= (state == st_done) && !ddr_rst;
        end
    end

    // prime fetches the first word, issue prefetches the next one
    assign rd_en    = (state == st_prime) || ((state == st_issue) && !fields.done);
    assign rd_addr  = addr_q;
    assign issue_en = (state == st_issue) && !ddr_rst;   // abort leaves bus at NOP
    assign load     = (state == st_issue) && need_pause; // also clears a stale count
    assign busy     = (state != st_idle);
    assign run_busy = busy;

endmodule

/* logic/pause_timer.sv */
`timescale 1ns/1ns

module pause_timer (
    input  logic                              mclk,
    input  logic                              rst,
    input  logic                              load,        // start a stretch
    input  logic [ddrseq_pkg::pause_bits-1:0] pause_len,   // from decoded NOP word
    output logic                              expired      // count reached zero
);
    import ddrseq_pkg::*;

    logic [pause_bits-1:0] cnt;                        // remaining pause cycles

    // the load cycle itself counts as the first pause cycle,
    // so the register starts one below the length and expired
    // comes up pause_len cycles after the load cycle
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (load) begin
            if (pause_len != '0) begin
                cnt <= pause_len - 1'b1;
            end else begin
                cnt <= '0;                             // add_pause only, nothing to count
            end
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;                         // park at zero
        end
    end

    assign expired = (cnt == '0);

endmodule

/* logic/cmd_issue.sv */
`timescale 1ns/1ns

module cmd_issue (
    input  logic                                 mclk,
    input  logic                                 rst,
    input  logic [ddrseq_pkg::cmd_word_bits-1:0] rd_word,    // from command memory
    input  logic                                 issue_en,   // put decoded cmd on bus
    output ddrseq_pkg::cmd_fields_t              fields,     // comb decode
    output ddrseq_pkg::ddr_cmd_t                 ddr_cmd     // registered bus
);
    import ddrseq_pkg::*;

    ddr_op_e op;                                       // strobe class of current word

    // word decode
    always_comb begin
        op               = ddr_op_e'({rd_word[ras_n_bit],
                                      rd_word[cas_n_bit],
                                      rd_word[we_n_bit]});
        fields.done      = rd_word[done_bit];
        fields.add_pause = rd_word[add_pause_bit];
        if (op == op_nop) begin
            fields.cmd       = nop_cmd;                // bank/addr not driven on NOPs
            fields.pause_len = rd_word[addr_lsb +: pause_bits];   // stretch from addr field
        end else begin
            fields.cmd.ras_n = rd_word[ras_n_bit];
            fields.cmd.cas_n = rd_word[cas_n_bit];
            fields.cmd.we_n  = rd_word[we_n_bit];
            fields.cmd.ba    = rd_word[ba_lsb +: ddr_bank_bits];
            fields.cmd.addr  = rd_word[addr_lsb +: ddr_addr_bits];
            fields.pause_len = '0;                     // only NOPs stretch
        end
    end

    // command bus register
    // exactly one cycle per issued word, NOP otherwise
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            ddr_cmd <= nop_cmd;
        end else if (issue_en) begin
            ddr_cmd <= fields.cmd;
        end else begin
            ddr_cmd <= nop_cmd;                        // fill between commands
        end
    end

endmodule

/* logic/cmd_mem.sv */
`timescale 1ns/1ns

module cmd_mem (
    input  logic                                   mclk,
    input  logic                                   rst,
    input  ddrseq_pkg::apb_req_t                   apb_req,
    output logic                                   pready,
    input  logic                                   busy,      // sequence running
    input  logic                                   rd_en,     // fetch strobe from fsm
    input  logic [ddrseq_pkg::cmd_addr_bits-1:0]   rd_addr,
    output logic [ddrseq_pkg::cmd_word_bits-1:0]   rd_word    // registered read data
);
    import ddrseq_pkg::*;

    logic [cmd_word_bits-1:0] mem [0:cmd_words-1];   // command words, no reset

    logic                     wr_en;
    logic [cmd_addr_bits-1:0] wr_addr;
    logic                     apb_access;

    // apb slave
    // setup phase is psel alone, access phase adds penable
    // no wait states while idle, master holds access phase while busy

    assign pready     = !busy;                         // stall writes during a run
    assign apb_access = apb_req.psel && apb_req.penable;
    assign wr_addr    = apb_req.paddr[word_lsb +: cmd_addr_bits];   // byte to word

    // reads over apb complete as no-ops
    assign wr_en = apb_access && apb_req.pwrite && pready;

    // write port
    always_ff @(posedge mclk) begin
        if (wr_en) begin
            mem[wr_addr] <= apb_req.pwdata;            // full word, no byte strobes
        end
    end

    // read port
    // one cycle latency, holds when rd_en is low so a stalled
    // fetch keeps the prefetched word for cmd_issue
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            rd_word <= '0;                             // decode input known after reset
        end else if (rd_en) begin
            rd_word <= mem[rd_addr];
        end
    end

    // note that a write and a fetch to the same word never overlap
    // since writes only land while busy is low and fetches only
    // happen while busy is high

endmodule

/* logic/ddrseq_pkg.sv */
package ddrseq_pkg;

    // command memory geometry
    localparam int cmd_addr_bits = 10;                   // word address into command memory
    localparam int cmd_words     = 1 << cmd_addr_bits;   // 1K words
    localparam int cmd_word_bits = 32;

    // ddr3 command bus widths
    localparam int ddr_addr_bits = 15;                   // a[14:0], 4Gb x16 part
    localparam int ddr_bank_bits = 3;                    // ba[2:0]

    localparam int pause_bits    = 10;                   // NOP stretch length

    // apb side
    localparam int apb_addr_bits = 12;                   // byte address
    localparam int word_lsb      = 2;                    // paddr[11:2] picks the word

    // command word layout
    localparam int done_bit      = 31;                   // last word of the sequence
    localparam int add_pause_bit = 30;                   // one extra NOP after this word
    localparam int ras_n_bit     = 29;
    localparam int cas_n_bit     = 28;
    localparam int we_n_bit      = 27;
    localparam int ba_lsb        = 24;                   // bank in [26:24]
    localparam int addr_lsb      = 0;                    // address in [14:0], [23:15] reserved

    // {ras_n, cas_n, we_n} decode, per ddr3 truth table
    typedef enum logic [2:0] {
        op_mode_reg  = 3'b000,
        op_refresh   = 3'b001,
        op_precharge = 3'b010,
        op_activate  = 3'b011,
        op_write     = 3'b100,
        op_read      = 3'b101,
        op_zq_cal    = 3'b110,
        op_nop       = 3'b111
    } ddr_op_e;

    // what goes out on the command pins, 21 bits
    typedef struct packed {
        logic                     ras_n;
        logic                     cas_n;
        logic                     we_n;
        logic [ddr_bank_bits-1:0] ba;
        logic [ddr_addr_bits-1:0] addr;
    } ddr_cmd_t;

    // decoded command word, 33 bits
    typedef struct packed {
        ddr_cmd_t              cmd;        // nop_cmd for NOP words
        logic                  done;
        logic                  add_pause;
        logic [pause_bits-1:0] pause_len;  // zero unless NOP word
    } cmd_fields_t;

    // apb master request, write only
    typedef struct packed {
        logic                     psel;
        logic                     penable;
        logic                     pwrite;
        logic [apb_addr_bits-1:0] paddr;
        logic [cmd_word_bits-1:0] pwdata;
    } apb_req_t;

    // sequencer states
    typedef enum logic [2:0] {
        st_idle  = 3'd0,
        st_prime = 3'd1,   // memory read latency
        st_issue = 3'd2,
        st_pause = 3'd3,
        st_done  = 3'd4
    } seq_state_e;

    // idle value of the command bus
    localparam ddr_cmd_t nop_cmd = '{
        ras_n: 1'b1,
        cas_n: 1'b1,
        we_n:  1'b1,
        ba:    '0,
        addr:  '0
    };

endpackage
